// ==== vlog.f ====
rtl/mips_pkg.sv
rtl/pipe_ifs.sv
rtl/fetch_stage.sv
rtl/regfile.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/mips_top.sv
testbench/wb_checker.sv
testbench/tb_top.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --top-module tb_top -f vlog.f -o sim_tb

out=$(./obj_dir/sim_tb)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'RESULT: PASS'; then
    exit 0
fi
exit 1

// ==== testbench/tb_top.sv ====
module tb_top;
    import mips_pkg::*;

    localparam int PROG_LEN = 400;
    localparam int CLK_HALF = 20;
    localparam int TIMEOUT  = PROG_LEN * 4 * 2 * CLK_HALF + 400 * 2 * CLK_HALF;

    logic            clk;
    logic            arst_n;
    logic            inst_stall;
    logic            data_stall;
    addr_t           inst_addr;
    inst_t           inst_rdata;
    logic            dram_ren;
    logic [BE_W-1:0] dram_wen;
    addr_t           dram_addr;
    word_t           dram_wdata;
    word_t           dram_rdata;
    addr_t           wb_pc;
    logic [BE_W-1:0] wb_wen;
    reg_addr_t       wb_num;
    word_t           wb_data;
    logic            done;
    int              err_cnt;
    int              wr_cnt;
    int              st_cnt;
    logic [31:0]     lfsr;
    addr_t           ioff;
    inst_t           prog [0:511];
    word_t           dmem [0:63];

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // registers limited to $0..$7 so dependencies show up often
    task automatic build_program();
        logic [3:0] kind;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        imm16_t     imm;
        for (int i = 0; i < 512; i++) begin
            prog[i] = '0;
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            kind = 4'(take_bits(4));
            rs   = 5'(take_bits(3));
            rt   = 5'(take_bits(3));
            rd   = 5'(take_bits(3));
            imm  = 16'(take_bits(16));
            case (kind)
                4'd0:        prog[i] = {OP_SPECIAL, rs, rt, rd, 5'd0, FN_ADDU};
                4'd1:        prog[i] = {OP_SPECIAL, rs, rt, rd, 5'd0, FN_SUBU};
                4'd2:        prog[i] = {OP_SPECIAL, rs, rt, rd, 5'd0, FN_AND};
                4'd3:        prog[i] = {OP_SPECIAL, rs, rt, rd, 5'd0, FN_OR};
                4'd4:        prog[i] = {OP_SPECIAL, rs, rt, rd, 5'd0, FN_XOR};
                4'd5:        prog[i] = {OP_SPECIAL, rs, rt, rd, 5'd0, FN_SLT};
                4'd6, 4'd7:  prog[i] = {OP_ADDIU, rs, rt, imm};
                4'd8:        prog[i] = {OP_ORI, rs, rt, imm};
                4'd9:        prog[i] = {OP_LUI, 5'd0, rt, imm};
                4'd10, 4'd11: prog[i] = {OP_LW, 5'd0, rt, 8'd0, imm[5:0], 2'b00};
                4'd12, 4'd13: prog[i] = {OP_SW, 5'd0, rt, 8'd0, imm[5:0], 2'b00};
                4'd14:       prog[i] = {6'h0c, rs, rt, imm};   // andi is not implemented
                default:     prog[i] = {OP_SPECIAL, rs, rt, rd, 5'd0, 6'h00};   // sll acts as no-op
            endcase
        end
    endtask

    task automatic report_counts();
        $display("checker: %0d register writes, %0d stores, %0d errors", wr_cnt, st_cnt, err_cnt);
    endtask

    assign ioff       = (inst_addr - RESET_PC) >> 2;
    assign inst_rdata = (ioff < 32'(PROG_LEN)) ? prog[ioff[8:0]] : '0;
    assign dram_rdata = dmem[dram_addr[7:2]];

    always @(posedge clk) begin
        if (!arst_n) begin
            for (int i = 0; i < 64; i++) begin
                dmem[i] <= '0;
            end
        end else if (dram_wen != '0) begin
            dmem[dram_addr[7:2]] <= dram_wdata;
        end
    end

    mips_top i_mips_top (
        .clk_i             (clk),
        .arst_n_i          (arst_n),
        .inst_sram_addr_o  (inst_addr),
        .inst_sram_rdata_i (inst_rdata),
        .data_sram_ren_o   (dram_ren),
        .data_sram_wen_o   (dram_wen),
        .data_sram_addr_o  (dram_addr),
        .data_sram_wdata_o (dram_wdata),
        .data_sram_rdata_i (dram_rdata),
        .debug_wb_pc_o     (wb_pc),
        .debug_wb_wen_o    (wb_wen),
        .debug_wb_num_o    (wb_num),
        .debug_wb_data_o   (wb_data),
        .inst_stall_i      (inst_stall),
        .data_stall_i      (data_stall)
    );

    wb_checker #(.PROG_LEN(PROG_LEN)) i_checker (
        .clk_i        (clk),
        .arst_n_i     (arst_n),
        .inst_addr_i  (inst_addr),
        .inst_data_i  (inst_rdata),
        .inst_stall_i (inst_stall),
        .data_stall_i (data_stall),
        .wb_wen_i     (wb_wen),
        .wb_pc_i      (wb_pc),
        .wb_num_i     (wb_num),
        .wb_data_i    (wb_data),
        .ram_ren_i    (dram_ren),
        .ram_wen_i    (dram_wen),
        .ram_addr_i   (dram_addr),
        .ram_wdata_i  (dram_wdata),
        .done_o       (done),
        .err_cnt_o    (err_cnt),
        .wr_cnt_o     (wr_cnt),
        .st_cnt_o     (st_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_HALF) clk = ~clk;
    end

    initial begin
        lfsr       = 32'h5c8e;
        arst_n     = 1'b0;
        inst_stall = 1'b0;
        data_stall = 1'b0;
        build_program();
        repeat (8) @(negedge clk);
        arst_n = 1'b1;
        while (!done) begin
            @(negedge clk);
            inst_stall = (take_bits(3) == 32'd0);   // about one cycle in eight
            data_stall = (take_bits(3) == 32'd0);
        end
        report_counts();
        if (err_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT);
        $display("watchdog: run timed out before the program drained");
        report_counts();
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== testbench/wb_checker.sv ====
module wb_checker #(
    parameter int PROG_LEN = 400
) (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  mips_pkg::addr_t           inst_addr_i,
    input  mips_pkg::inst_t           inst_data_i,
    input  logic                      inst_stall_i,
    input  logic                      data_stall_i,
    input  logic [mips_pkg::BE_W-1:0] wb_wen_i,
    input  mips_pkg::addr_t           wb_pc_i,
    input  mips_pkg::reg_addr_t       wb_num_i,
    input  mips_pkg::word_t           wb_data_i,
    input  logic                      ram_ren_i,
    input  logic [mips_pkg::BE_W-1:0] ram_wen_i,
    input  mips_pkg::addr_t           ram_addr_i,
    input  mips_pkg::word_t           ram_wdata_i,
    output logic                      done_o,
    output int                        err_cnt_o,
    output int                        wr_cnt_o,
    output int                        st_cnt_o
);
    import mips_pkg::*;

    // a few words past the end so the last instruction has drained
    localparam addr_t END_PC = RESET_PC + 32'(4 * (PROG_LEN + 8));

    inst_t fetched [0:511];
    logic  seen    [0:511];
    word_t regs    [0:31];
    word_t mem     [0:63];
    int    midx    = 0;   // next instruction for the model
    int    err_cnt = 0;
    int    wr_cnt  = 0;
    int    st_cnt  = 0;
    logic  done    = 1'b0;
    addr_t off;

    logic      pend_we = 1'b0;   // load write still owed after its request
    addr_t     pend_pc;
    reg_addr_t pend_dst;
    word_t     pend_d;

    assign off       = inst_addr_i - RESET_PC;
    assign done_o    = done;
    assign err_cnt_o = err_cnt;
    assign wr_cnt_o  = wr_cnt;
    assign st_cnt_o  = st_cnt;

    task automatic compare_field(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Mismatch at time %0t: %s got %h expected %h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    // runs the model to its next visible effect (1 register write, 2 store, 3 load request)
    task automatic next_event(output int kind, output addr_t pc, output word_t a, output word_t d);
        inst_t     inst;
        word_t     rs_v;
        word_t     rt_v;
        word_t     sext;
        reg_addr_t dst;
        kind = 0;
        pc   = '0;
        a    = '0;
        d    = '0;
        if (pend_we) begin
            kind    = 1;
            pc      = pend_pc;
            a       = 32'(pend_dst);
            d       = pend_d;
            pend_we = 1'b0;
        end
        while (kind == 0 && midx < PROG_LEN) begin
            inst = fetched[midx[8:0]];
            pc   = RESET_PC + 32'(midx * 4);
            if (!seen[midx[8:0]]) begin
                $display("instruction at pc %h retired without having been fetched", pc);
                err_cnt++;
            end
            midx++;
            rs_v = regs[inst[25:21]];
            rt_v = regs[inst[20:16]];
            sext = {{16{inst[15]}}, inst[15:0]};
            dst  = inst[20:16];
            kind = 1;
            case (inst[31:26])
                OP_SPECIAL: begin
                    dst = inst[15:11];
                    case (inst[5:0])
                        FN_ADDU: d = rs_v + rt_v;
                        FN_SUBU: d = rs_v - rt_v;
                        FN_AND:  d = rs_v & rt_v;
                        FN_OR:   d = rs_v | rt_v;
                        FN_XOR:  d = rs_v ^ rt_v;
                        FN_SLT:  d = ($signed(rs_v) < $signed(rt_v)) ? 32'd1 : 32'd0;
                        default: kind = 0;
                    endcase
                end
                OP_ADDIU: d = rs_v + sext;
                OP_ORI:   d = rs_v | {16'h0000, inst[15:0]};
                OP_LUI:   d = {inst[15:0], 16'h0000};
                OP_LW: begin
                    kind = 3;   // the register write follows as its own event
                    a    = rs_v + sext;
                    d    = mem[a[7:2]];
                    if (dst != 5'd0) begin
                        regs[dst] = d;
                        pend_we   = 1'b1;
                        pend_pc   = pc;
                        pend_dst  = dst;
                        pend_d    = d;
                    end
                end
                OP_SW: begin
                    kind         = 2;
                    a            = rs_v + sext;
                    d            = rt_v;
                    mem[a[7:2]]  = rt_v;
                end
                default: kind = 0;
            endcase
            if (kind == 1) begin
                if (dst == 5'd0) begin
                    kind = 0;   // $0 never changes
                end else begin
                    regs[dst] = d;
                    a         = 32'(dst);
                end
            end
        end
    endtask

    always @(posedge clk_i) begin
        int    kind;
        int    missing;
        addr_t pc;
        word_t a;
        word_t d;
        if (!arst_n_i) begin
            for (int i = 0; i < 512; i++) begin
                seen[i] = 1'b0;
            end
            for (int i = 0; i < 32; i++) begin
                regs[i] = '0;
            end
            for (int i = 0; i < 64; i++) begin
                mem[i] = '0;
            end
        end else if (!done) begin
            if (off < 32'(4 * PROG_LEN) && off[1:0] == 2'b00) begin
                fetched[off[10:2]] = inst_data_i;
                seen[off[10:2]]    = 1'b1;
            end
            // writeback is older than the request in MEM and goes first
            if (!inst_stall_i && !data_stall_i) begin
                if (wb_wen_i != '0) begin
                    wr_cnt++;
                    next_event(kind, pc, a, d);
                    if (kind != 1) begin
                        $display("register write from pc %h at time %0t was not expected",
                                 wb_pc_i, $time);
                        err_cnt++;
                    end else begin
                        compare_field("debug_wb_wen_o", 32'(wb_wen_i), 32'hf);
                        compare_field("debug_wb_pc_o", wb_pc_i, pc);
                        compare_field("debug_wb_num_o", 32'(wb_num_i), a);
                        compare_field("debug_wb_data_o", wb_data_i, d);
                    end
                end
                if (ram_ren_i) begin
                    next_event(kind, pc, a, d);
                    if (kind != 3) begin
                        $display("load from %h at time %0t was not expected",
                                 ram_addr_i, $time);
                        err_cnt++;
                    end else begin
                        compare_field("data_sram_addr_o", ram_addr_i, a);
                    end
                end
                if (ram_wen_i != '0) begin
                    st_cnt++;
                    next_event(kind, pc, a, d);
                    if (kind != 2) begin
                        $display("store to %h at time %0t was not expected",
                                 ram_addr_i, $time);
                        err_cnt++;
                    end else begin
                        compare_field("data_sram_wen_o", 32'(ram_wen_i), 32'hf);
                        compare_field("data_sram_addr_o", ram_addr_i, a);
                        compare_field("data_sram_wdata_o", ram_wdata_i, d);
                    end
                end
            end else if (wb_wen_i != '0) begin
                $display("register write from pc %h at time %0t shown during a stall",
                         wb_pc_i, $time);
                err_cnt++;
            end
            if (inst_addr_i >= END_PC) begin
                missing = 0;
                next_event(kind, pc, a, d);
                while (kind != 0) begin
                    missing++;
                    next_event(kind, pc, a, d);
                end
                if (missing > 0) begin
                    $display("program end reached with %0d expected writes or requests never seen",
                             missing);
                    err_cnt++;
                end
                done = 1'b1;
            end
        end
    end

endmodule

// ==== rtl/mips_top.sv ====
module mips_top (
    input  logic                      clk_i,
    input  logic                      arst_n_i,

    output mips_pkg::addr_t           inst_sram_addr_o,
    input  mips_pkg::inst_t           inst_sram_rdata_i,

    output logic                      data_sram_ren_o,
    output logic [mips_pkg::BE_W-1:0] data_sram_wen_o,
    output mips_pkg::addr_t           data_sram_addr_o,
    output mips_pkg::word_t           data_sram_wdata_o,
    input  mips_pkg::word_t           data_sram_rdata_i,

    output mips_pkg::addr_t           debug_wb_pc_o,
    output logic [mips_pkg::BE_W-1:0] debug_wb_wen_o,
    output mips_pkg::reg_addr_t       debug_wb_num_o,
    output mips_pkg::word_t           debug_wb_data_o,

    input  logic                      inst_stall_i,
    input  logic                      data_stall_i
);
    import mips_pkg::*;

    logic      stall_all;
    logic      load_use;
    inst_t     if_id_inst;
    addr_t     if_id_pc;
    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    word_t     rs_data;
    word_t     rt_data;
    logic      ex_byp_we;
    reg_addr_t ex_byp_reg;
    word_t     ex_byp_data;
    logic      mem_byp_we;
    reg_addr_t mem_byp_reg;
    word_t     mem_byp_data;

    id_ex_if  id_ex ();
    ex_mem_if ex_mem ();
    wb_if     wb ();

    assign stall_all = inst_stall_i || data_stall_i;   // freezes every stage

    // one debug write per retired instruction
    assign debug_wb_wen_o  = stall_all ? '0 : {BE_W{wb.reg_we}};
    assign debug_wb_pc_o   = wb.pc;
    assign debug_wb_num_o  = wb.dest;
    assign debug_wb_data_o = wb.data;

    fetch_stage i_fetch (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .stall_i    (stall_all),
        .load_use_i (load_use),
        .pc_o       (inst_sram_addr_o),
        .inst_i     (inst_sram_rdata_i),
        .id_inst_o  (if_id_inst),
        .id_pc_o    (if_id_pc)
    );

    regfile i_regfile (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .rs_addr_i (rs_addr),
        .rt_addr_i (rt_addr),
        .rs_data_o (rs_data),
        .rt_data_o (rt_data),
        .wb        (wb.dst)
    );

    decode_stage i_decode (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .stall_i        (stall_all),
        .inst_i         (if_id_inst),
        .pc_i           (if_id_pc),
        .rs_addr_o      (rs_addr),
        .rt_addr_o      (rt_addr),
        .rs_data_i      (rs_data),
        .rt_data_i      (rt_data),
        .ex_byp_we_i    (ex_byp_we),
        .ex_byp_reg_i   (ex_byp_reg),
        .ex_byp_data_i  (ex_byp_data),
        .mem_byp_we_i   (mem_byp_we),
        .mem_byp_reg_i  (mem_byp_reg),
        .mem_byp_data_i (mem_byp_data),
        .load_use_o     (load_use),
        .id_ex          (id_ex.src)
    );

    execute_stage i_execute (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .stall_i    (stall_all),
        .id_ex      (id_ex.dst),
        .ex_mem     (ex_mem.src),
        .byp_we_o   (ex_byp_we),
        .byp_reg_o  (ex_byp_reg),
        .byp_data_o (ex_byp_data)
    );

    memory_stage i_memory (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .stall_i     (stall_all),
        .ex_mem      (ex_mem.dst),
        .ram_ren_o   (data_sram_ren_o),
        .ram_wen_o   (data_sram_wen_o),
        .ram_addr_o  (data_sram_addr_o),
        .ram_wdata_o (data_sram_wdata_o),
        .ram_rdata_i (data_sram_rdata_i),
        .byp_we_o    (mem_byp_we),
        .byp_reg_o   (mem_byp_reg),
        .byp_data_o  (mem_byp_data),
        .wb          (wb.src)
    );

endmodule

// ==== rtl/memory_stage.sv ====
module memory_stage (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  logic                     stall_i,
    ex_mem_if.dst                    ex_mem,
    output logic                     ram_ren_o,
    output logic [mips_pkg::BE_W-1:0] ram_wen_o,
    output mips_pkg::addr_t          ram_addr_o,
    output mips_pkg::word_t          ram_wdata_o,
    input  mips_pkg::word_t          ram_rdata_i,
    output logic                     byp_we_o,
    output mips_pkg::reg_addr_t      byp_reg_o,
    output mips_pkg::word_t          byp_data_o,
    wb_if.src                        wb
);
    import mips_pkg::*;

    word_t wr_data;

    assign ram_ren_o   = ex_mem.is_load;
    assign ram_wen_o   = {BE_W{ex_mem.is_store}};   // word stores only
    assign ram_addr_o  = ex_mem.result;
    assign ram_wdata_o = ex_mem.st_data;

    assign wr_data = ex_mem.is_load ? ram_rdata_i : ex_mem.result;

    assign byp_we_o   = ex_mem.reg_we;
    assign byp_reg_o  = ex_mem.dest;
    assign byp_data_o = wr_data;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb.reg_we <= 1'b0;
        end else if (!stall_i) begin
            wb.reg_we <= ex_mem.reg_we;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            wb.pc   <= ex_mem.pc;
            wb.dest <= ex_mem.dest;
            wb.data <= wr_data;
        end
    end

endmodule

// ==== rtl/execute_stage.sv ====
module execute_stage (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  logic                stall_i,
    id_ex_if.dst                id_ex,
    ex_mem_if.src               ex_mem,
    output logic                byp_we_o,
    output mips_pkg::reg_addr_t byp_reg_o,
    output mips_pkg::word_t     byp_data_o
);
    import mips_pkg::*;

    word_t result;

    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD: result = id_ex.op_a + id_ex.op_b;
            ALU_SUB: result = id_ex.op_a - id_ex.op_b;
            ALU_AND: result = id_ex.op_a & id_ex.op_b;
            ALU_OR:  result = id_ex.op_a | id_ex.op_b;
            ALU_XOR: result = id_ex.op_a ^ id_ex.op_b;
            ALU_SLT: result = {31'd0, $signed(id_ex.op_a) < $signed(id_ex.op_b)};
            ALU_LUI: result = {id_ex.op_b[15:0], 16'h0000};
            default: result = '0;
        endcase
    end

    // a load only has its address here
    assign byp_we_o   = id_ex.reg_we && !id_ex.is_load;
    assign byp_reg_o  = id_ex.dest;
    assign byp_data_o = result;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_mem.reg_we   <= 1'b0;
            ex_mem.is_load  <= 1'b0;
            ex_mem.is_store <= 1'b0;
        end else if (!stall_i) begin
            ex_mem.reg_we   <= id_ex.reg_we;
            ex_mem.is_load  <= id_ex.is_load;
            ex_mem.is_store <= id_ex.is_store;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            ex_mem.pc      <= id_ex.pc;
            ex_mem.result  <= result;
            ex_mem.st_data <= id_ex.st_data;
            ex_mem.dest    <= id_ex.dest;
        end
    end

endmodule

// ==== rtl/decode_stage.sv ====
module decode_stage (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  logic                stall_i,
    input  mips_pkg::inst_t     inst_i,
    input  mips_pkg::addr_t     pc_i,
    output mips_pkg::reg_addr_t rs_addr_o,
    output mips_pkg::reg_addr_t rt_addr_o,
    input  mips_pkg::word_t     rs_data_i,
    input  mips_pkg::word_t     rt_data_i,
    input  logic                ex_byp_we_i,
    input  mips_pkg::reg_addr_t ex_byp_reg_i,
    input  mips_pkg::word_t     ex_byp_data_i,
    input  logic                mem_byp_we_i,
    input  mips_pkg::reg_addr_t mem_byp_reg_i,
    input  mips_pkg::word_t     mem_byp_data_i,
    output logic                load_use_o,
    id_ex_if.src                id_ex
);
    import mips_pkg::*;

    opcode_t   op;
    opcode_t   fn;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    imm16_t    imm;

    alu_op_e   alu_op;
    reg_addr_t dst;
    logic      reg_we;
    logic      is_load;
    logic      is_store;
    logic      use_rs;
    logic      use_rt;
    logic      b_is_imm;
    logic      imm_zext;
    word_t     imm_ext;
    word_t     rs_val;
    word_t     rt_val;

    assign op  = inst_i[31:26];
    assign rs  = inst_i[25:21];
    assign rt  = inst_i[20:16];
    assign rd  = inst_i[15:11];
    assign fn  = inst_i[5:0];
    assign imm = inst_i[15:0];

    assign rs_addr_o = rs;
    assign rt_addr_o = rt;

    always_comb begin
        alu_op   = ALU_ADD;
        dst      = rt;
        reg_we   = 1'b0;
        is_load  = 1'b0;
        is_store = 1'b0;
        use_rs   = 1'b0;
        use_rt   = 1'b0;
        b_is_imm = 1'b1;
        imm_zext = 1'b0;
        case (op)
            OP_SPECIAL: begin
                dst      = rd;
                b_is_imm = 1'b0;
                reg_we   = 1'b1;
                use_rs   = 1'b1;
                use_rt   = 1'b1;
                case (fn)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    default: begin
                        reg_we = 1'b0;   // unsupported funct is a no-op
                        use_rs = 1'b0;
                        use_rt = 1'b0;
                    end
                endcase
            end
            OP_ADDIU: begin
                reg_we = 1'b1;
                use_rs = 1'b1;
            end
            OP_ORI: begin
                alu_op   = ALU_OR;
                imm_zext = 1'b1;
                reg_we   = 1'b1;
                use_rs   = 1'b1;
            end
            OP_LUI: begin
                alu_op   = ALU_LUI;
                imm_zext = 1'b1;
                reg_we   = 1'b1;
            end
            OP_LW: begin
                is_load = 1'b1;
                reg_we  = 1'b1;
                use_rs  = 1'b1;
            end
            OP_SW: begin
                is_store = 1'b1;
                use_rs   = 1'b1;
                use_rt   = 1'b1;   // store data
            end
            default: ;
        endcase
        if (dst == '0) begin
            reg_we = 1'b0;
        end
    end

    assign imm_ext = imm_zext ? {16'h0000, imm} : {{16{imm[15]}}, imm};

    // EX beats MEM beats the register file
    assign rs_val = (ex_byp_we_i  && ex_byp_reg_i  == rs) ? ex_byp_data_i  :
                    (mem_byp_we_i && mem_byp_reg_i == rs) ? mem_byp_data_i : rs_data_i;
    assign rt_val = (ex_byp_we_i  && ex_byp_reg_i  == rt) ? ex_byp_data_i  :
                    (mem_byp_we_i && mem_byp_reg_i == rt) ? mem_byp_data_i : rt_data_i;

    // load in EX has no value yet
    assign load_use_o = id_ex.is_load && id_ex.reg_we &&
                        ((use_rs && rs == id_ex.dest) || (use_rt && rt == id_ex.dest));

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            id_ex.reg_we   <= 1'b0;
            id_ex.is_load  <= 1'b0;
            id_ex.is_store <= 1'b0;
        end else if (!stall_i) begin
            id_ex.reg_we   <= reg_we   && !load_use_o;   // bubble on load-use
            id_ex.is_load  <= is_load  && !load_use_o;
            id_ex.is_store <= is_store && !load_use_o;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            id_ex.pc      <= pc_i;
            id_ex.op_a    <= rs_val;
            id_ex.op_b    <= b_is_imm ? imm_ext : rt_val;
            id_ex.st_data <= rt_val;
            id_ex.alu_op  <= alu_op;
            id_ex.dest    <= dst;
        end
    end

endmodule

// ==== rtl/regfile.sv ====
module regfile (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  mips_pkg::reg_addr_t rs_addr_i,
    input  mips_pkg::reg_addr_t rt_addr_i,
    output mips_pkg::word_t     rs_data_o,
    output mips_pkg::word_t     rt_data_o,
    wb_if.dst                   wb
);
    import mips_pkg::*;

    word_t gpr [1:31];   // $0 is not stored

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                gpr[i] <= '0;
            end
        end else if (wb.reg_we && wb.dest != '0) begin
            gpr[wb.dest] <= wb.data;
        end
    end

    // write-through so ID sees the value retiring this cycle
    always_comb begin
        if (rs_addr_i == '0)                          rs_data_o = '0;
        else if (wb.reg_we && wb.dest == rs_addr_i)   rs_data_o = wb.data;
        else                                          rs_data_o = gpr[rs_addr_i];

        if (rt_addr_i == '0)                          rt_data_o = '0;
        else if (wb.reg_we && wb.dest == rt_addr_i)   rt_data_o = wb.data;
        else                                          rt_data_o = gpr[rt_addr_i];
    end

endmodule

// ==== rtl/fetch_stage.sv ====
module fetch_stage (
    input  logic            clk_i,
    input  logic            arst_n_i,
    input  logic            stall_i,
    input  logic            load_use_i,
    output mips_pkg::addr_t pc_o,
    input  mips_pkg::inst_t inst_i,
    output mips_pkg::inst_t id_inst_o,
    output mips_pkg::addr_t id_pc_o
);
    import mips_pkg::*;

    addr_t pc_q;
    logic  advance;

    assign advance = !stall_i && !load_use_i;
    assign pc_o    = pc_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= RESET_PC;
        end else if (advance) begin
            pc_q <= pc_q + PC_STEP;   // no branches, straight line only
        end
    end

    // all-zero word decodes as a no-op, so reset leaves a bubble in ID
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            id_inst_o <= '0;
        end else if (advance) begin
            id_inst_o <= inst_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (advance) begin
            id_pc_o <= pc_q;
        end
    end

endmodule

// ==== rtl/pipe_ifs.sv ====
// ID/EX bundle
interface id_ex_if;
    import mips_pkg::*;

    addr_t     pc;
    word_t     op_a;
    word_t     op_b;
    word_t     st_data;
    alu_op_e   alu_op;
    reg_addr_t dest;
    logic      reg_we;
    logic      is_load;
    logic      is_store;

    modport src (output pc, op_a, op_b, st_data, alu_op, dest, reg_we, is_load, is_store);
    modport dst (input  pc, op_a, op_b, st_data, alu_op, dest, reg_we, is_load, is_store);
endinterface

// EX/MEM bundle where result doubles as the lw/sw address
interface ex_mem_if;
    import mips_pkg::*;

    addr_t     pc;
    word_t     result;
    word_t     st_data;
    reg_addr_t dest;
    logic      reg_we;
    logic      is_load;
    logic      is_store;

    modport src (output pc, result, st_data, dest, reg_we, is_load, is_store);
    modport dst (input  pc, result, st_data, dest, reg_we, is_load, is_store);
endinterface

// MEM/WB bundle
interface wb_if;
    import mips_pkg::*;

    addr_t     pc;
    reg_addr_t dest;
    word_t     data;
    logic      reg_we;

    modport src (output pc, dest, data, reg_we);
    modport dst (input  pc, dest, data, reg_we);
endinterface

// ==== rtl/mips_pkg.sv ====
package mips_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;
    localparam int IMM_W  = 16;
    localparam int OP_W   = 6;
    localparam int BE_W   = 4;   // byte enables per data word

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [XLEN-1:0]   addr_t;
    typedef logic [XLEN-1:0]   inst_t;
    typedef logic [REG_AW-1:0] reg_addr_t;
    typedef logic [IMM_W-1:0]  imm16_t;
    typedef logic [OP_W-1:0]   opcode_t;

    // major opcodes, inst[31:26]
    localparam opcode_t OP_SPECIAL = 6'h00;
    localparam opcode_t OP_ADDIU   = 6'h09;
    localparam opcode_t OP_ORI     = 6'h0d;
    localparam opcode_t OP_LUI     = 6'h0f;
    localparam opcode_t OP_LW      = 6'h23;
    localparam opcode_t OP_SW      = 6'h2b;

    // function field of SPECIAL, inst[5:0]
    localparam opcode_t FN_ADDU = 6'h21;
    localparam opcode_t FN_SUBU = 6'h23;
    localparam opcode_t FN_AND  = 6'h24;
    localparam opcode_t FN_OR   = 6'h25;
    localparam opcode_t FN_XOR  = 6'h26;
    localparam opcode_t FN_SLT  = 6'h2a;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5,   // signed compare
        ALU_LUI = 3'd6
    } alu_op_e;

    localparam addr_t RESET_PC = 32'hbfc00000;   // boot vector in kseg1
    localparam addr_t PC_STEP  = 32'd4;

endpackage
